/* source/csr_settings.svh */
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

// ====================
// widths
// ====================
`define CSR_ADDR_W 14
`define CSR_DATA_W 32
`define HWI_W 8

// ====================
// csr numbers
// ====================
`define CSR_CRMD   14'h000
`define CSR_PRMD   14'h001
`define CSR_ECFG   14'h004
`define CSR_ESTAT  14'h005
`define CSR_ERA    14'h006
`define CSR_EENTRY 14'h00c
`define CSR_SAVE0  14'h030
`define CSR_SAVE1  14'h031
`define CSR_SAVE2  14'h032
`define CSR_SAVE3  14'h033
`define CSR_TCFG   14'h041
`define CSR_TVAL   14'h042
`define CSR_TICLR  14'h044

// reset values and masks
`define CRMD_RESET 32'h0000_0008
// local enables for TI at bit 11 and HWI and SWI below bit 10
`define ECFG_LIE_MASK 13'h0bff

`endif

/* source/csr_pkg.sv */
`default_nettype none

`include "csr_settings.svh"

package csr_pkg;

    typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;

    // current mode
    typedef struct packed {
        logic [22:0] rsvd;
        logic [1:0]  datm;
        logic [1:0]  datf;
        logic        pg;
        logic        da;
        logic        ie;
        logic [1:0]  plv;
    } crmd_t;

    // saved mode on exception entry
    typedef struct packed {
        logic [28:0] rsvd;
        logic        pie;
        logic [1:0]  pplv;
    } prmd_t;

    typedef struct packed {
        logic [29:0] initval;
        logic        periodic;
        logic        en;
    } tcfg_t;

    typedef struct packed {
        logic              rsvd31;
        logic [8:0]        esubcode;
        logic [5:0]        ecode;
        logic [3:0]        rsvd15_12;
        logic              ti;
        logic              rsvd10;
        logic [`HWI_W-1:0] hwi;
        logic [1:0]        swi;
    } estat_t;

    // one csr word as each owner decodes it
    typedef union packed {
        logic [`CSR_DATA_W-1:0] raw;
        crmd_t                  crmd;
        prmd_t                  prmd;
        tcfg_t                  tcfg;
        estat_t                 estat;
    } csr_word_u;

endpackage

`default_nettype wire

/* source/csr_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface csr_bus_if;

    logic               wr_en;
    csr_pkg::csr_addr_t wr_addr;
    csr_pkg::csr_word_u wr_data;
    csr_pkg::csr_addr_t rd_addr;

    // core side
    modport host (
        output wr_en, wr_addr, wr_data, rd_addr
    );

    // register owners that each decode their own numbers
    modport owner (
        input wr_en, wr_addr, wr_data, rd_addr
    );

endinterface

`default_nettype wire

/* source/trap_control.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_settings.svh"

module trap_control (
    input  logic                   clk,
    input  logic                   reset,
    csr_bus_if.owner               bus,
    input  logic                   excp_flush,
    input  logic                   ertn_flush,
    input  logic [31:0]            era_in,
    input  logic [5:0]             ecode_in,
    input  logic [8:0]             esubcode_in,
    input  logic [`HWI_W-1:0]      interrupt,
    input  logic                   ti_pending,
    output logic [`CSR_DATA_W-1:0] rd_data,
    output logic [31:0]            era,
    output logic [1:0]             plv,
    output logic                   has_int
);

    csr_pkg::crmd_t    crmd;
    csr_pkg::prmd_t    prmd;
    csr_pkg::estat_t   estat;
    logic [12:0]       ecfg_lie;
    logic [1:0]        estat_swi;
    logic [`HWI_W-1:0] estat_hwi;
    logic [5:0]        estat_ecode;
    logic [8:0]        estat_esubcode;
    logic [31:0]       era_q;
    logic [12:0]       int_status;
    logic              crmd_wen;
    logic              prmd_wen;
    logic              ecfg_wen;
    logic              estat_wen;
    logic              era_wen;

    assign crmd_wen  = bus.wr_en && (bus.wr_addr == `CSR_CRMD);
    assign prmd_wen  = bus.wr_en && (bus.wr_addr == `CSR_PRMD);
    assign ecfg_wen  = bus.wr_en && (bus.wr_addr == `CSR_ECFG);
    assign estat_wen = bus.wr_en && (bus.wr_addr == `CSR_ESTAT);
    assign era_wen   = bus.wr_en && (bus.wr_addr == `CSR_ERA);

    // ====================
    // mode state
    // ====================
    // exception entry beats return, both beat csr writes
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd <= `CRMD_RESET;
        end else if (excp_flush) begin
            crmd.plv <= 2'd0;
            crmd.ie  <= 1'b0;
        end else if (ertn_flush) begin
            crmd.plv <= prmd.pplv;
            crmd.ie  <= prmd.pie;
        end else if (crmd_wen) begin
            crmd.plv  <= bus.wr_data.crmd.plv;
            crmd.ie   <= bus.wr_data.crmd.ie;
            crmd.da   <= bus.wr_data.crmd.da;
            crmd.pg   <= bus.wr_data.crmd.pg;
            crmd.datf <= bus.wr_data.crmd.datf;
            crmd.datm <= bus.wr_data.crmd.datm;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prmd <= '0;
        end else if (excp_flush) begin
            prmd.pplv <= crmd.plv;
            prmd.pie  <= crmd.ie;
        end else if (prmd_wen && !ertn_flush) begin
            prmd.pplv <= bus.wr_data.prmd.pplv;
            prmd.pie  <= bus.wr_data.prmd.pie;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ecfg_lie <= '0;
        end else if (ecfg_wen) begin
            ecfg_lie <= bus.wr_data.raw[12:0] & `ECFG_LIE_MASK;
        end
    end

    // ====================
    // exception status
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            estat_swi      <= '0;
            estat_hwi      <= '0;
            estat_ecode    <= '0;
            estat_esubcode <= '0;
        end else begin
            // interrupt lines sampled once
            estat_hwi <= interrupt;
            if (excp_flush) begin
                estat_ecode    <= ecode_in;
                estat_esubcode <= esubcode_in;
            end else if (estat_wen) begin
                estat_swi <= bus.wr_data.estat.swi;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (excp_flush) begin
            era_q <= era_in;
        end else if (era_wen) begin
            era_q <= bus.wr_data.raw;
        end
    end

    always_comb begin
        estat          = '0;
        estat.swi      = estat_swi;
        estat.hwi      = estat_hwi;
        estat.ti       = ti_pending;
        estat.ecode    = estat_ecode;
        estat.esubcode = estat_esubcode;
    end

    assign int_status = {1'b0, estat.ti, 1'b0, estat.hwi, estat.swi};
    assign has_int    = crmd.ie && |(ecfg_lie & int_status);

    always_comb begin
        case (bus.rd_addr)
            `CSR_CRMD:  rd_data = crmd;
            `CSR_PRMD:  rd_data = prmd;
            `CSR_ECFG:  rd_data = {19'd0, ecfg_lie};
            `CSR_ESTAT: rd_data = estat;
            `CSR_ERA:   rd_data = era_q;
            default:    rd_data = '0;
        endcase
    end

    assign era = era_q;
    assign plv = crmd.plv;

endmodule

`default_nettype wire

/* source/countdown_timer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_settings.svh"

module countdown_timer (
    input  logic                   clk,
    input  logic                   reset,
    csr_bus_if.owner               bus,
    output logic                   ti_pending,
    output logic [`CSR_DATA_W-1:0] rd_data
);

    csr_pkg::tcfg_t tcfg;
    logic [31:0]    tval;
    logic           running;
    logic           ti_flag;
    logic           tcfg_wen;
    logic           ticlr_wen;
    logic           expire;

    assign tcfg_wen  = bus.wr_en && (bus.wr_addr == `CSR_TCFG);
    assign ticlr_wen = bus.wr_en && (bus.wr_addr == `CSR_TICLR);
    assign expire    = running && (tval == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg    <= '0;
            running <= 1'b0;
        end else if (tcfg_wen) begin
            tcfg    <= bus.wr_data.tcfg;
            running <= bus.wr_data.tcfg.en;
        end else if (expire) begin
            // one-shot stops here
            running <= tcfg.periodic;
        end
    end

    // load is initval times 4
    always_ff @(posedge clk) begin
        if (reset) begin
            tval <= '0;
        end else if (tcfg_wen) begin
            tval <= {bus.wr_data.tcfg.initval, 2'b00};
        end else if (expire) begin
            tval <= tcfg.periodic ? {tcfg.initval, 2'b00} : '1;
        end else if (running) begin
            tval <= tval - 32'd1;
        end
    end

    // clear wins over expiry
    always_ff @(posedge clk) begin
        if (reset) begin
            ti_flag <= 1'b0;
        end else if (ticlr_wen && bus.wr_data.raw[0]) begin
            ti_flag <= 1'b0;
        end else if (expire) begin
            ti_flag <= 1'b1;
        end
    end

    assign ti_pending = ti_flag;

    // TICLR falls to the default and reads zero
    always_comb begin
        case (bus.rd_addr)
            `CSR_TCFG: rd_data = tcfg;
            `CSR_TVAL: rd_data = tval;
            default:   rd_data = '0;
        endcase
    end

endmodule

`default_nettype wire

/* source/csr_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_settings.svh"

module csr_regfile (
    input  logic                   clk,
    input  logic                   reset,
    csr_bus_if.owner               bus,
    input  logic [`CSR_DATA_W-1:0] trap_rd_data,
    input  logic [`CSR_DATA_W-1:0] timer_rd_data,
    output logic [`CSR_DATA_W-1:0] rd_data,
    output logic [31:0]            eentry
);

    logic [25:0]            eentry_base;
    logic [`CSR_DATA_W-1:0] save_q [4];
    logic [`CSR_DATA_W-1:0] own_rd;
    logic                   eentry_wen;

    assign eentry_wen = bus.wr_en && (bus.wr_addr == `CSR_EENTRY);

    // entry is 64-byte aligned
    always_ff @(posedge clk) begin
        if (reset) begin
            eentry_base <= '0;
        end else if (eentry_wen) begin
            eentry_base <= bus.wr_data.raw[31:6];
        end
    end

    assign eentry = {eentry_base, 6'd0};

    // ====================
    // scratch registers
    // ====================
    always_ff @(posedge clk) begin
        if (bus.wr_en) begin
            case (bus.wr_addr)
                `CSR_SAVE0: save_q[0] <= bus.wr_data.raw;
                `CSR_SAVE1: save_q[1] <= bus.wr_data.raw;
                `CSR_SAVE2: save_q[2] <= bus.wr_data.raw;
                `CSR_SAVE3: save_q[3] <= bus.wr_data.raw;
                default: begin
                end
            endcase
        end
    end

    always_comb begin
        case (bus.rd_addr)
            `CSR_EENTRY: own_rd = eentry;
            `CSR_SAVE0:  own_rd = save_q[0];
            `CSR_SAVE1:  own_rd = save_q[1];
            `CSR_SAVE2:  own_rd = save_q[2];
            `CSR_SAVE3:  own_rd = save_q[3];
            default:     own_rd = '0;
        endcase
    end

    // ====================
    // read merge
    // ====================
    // each owner returns zero outside its own numbers
    assign rd_data = own_rd | trap_rd_data | timer_rd_data;

endmodule

`default_nettype wire

/* source/csr_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_settings.svh"

module csr_unit (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   csr_wr_en,
    input  logic [`CSR_ADDR_W-1:0] wr_addr,
    input  logic [`CSR_DATA_W-1:0] wr_data,
    input  logic [`CSR_ADDR_W-1:0] rd_addr,
    output logic [`CSR_DATA_W-1:0] rd_data,
    input  logic                   excp_flush,
    input  logic                   ertn_flush,
    input  logic [31:0]            era_in,
    input  logic [5:0]             ecode_in,
    input  logic [8:0]             esubcode_in,
    input  logic [`HWI_W-1:0]      interrupt,
    output logic                   has_int,
    output logic [31:0]            eentry,
    output logic [31:0]            era,
    output logic [1:0]             plv
);

    logic [`CSR_DATA_W-1:0] trap_rd_data;
    logic [`CSR_DATA_W-1:0] timer_rd_data;
    logic                   ti_pending;

    csr_bus_if bus ();

    // core requests onto the csr bus
    assign bus.wr_en   = csr_wr_en;
    assign bus.wr_addr = wr_addr;
    assign bus.wr_data = wr_data;
    assign bus.rd_addr = rd_addr;

    trap_control trap_control_i (
        .clk         (clk),
        .reset       (reset),
        .bus         (bus),
        .excp_flush  (excp_flush),
        .ertn_flush  (ertn_flush),
        .era_in      (era_in),
        .ecode_in    (ecode_in),
        .esubcode_in (esubcode_in),
        .interrupt   (interrupt),
        .ti_pending  (ti_pending),
        .rd_data     (trap_rd_data),
        .era         (era),
        .plv         (plv),
        .has_int     (has_int)
    );

    countdown_timer countdown_timer_i (
        .clk        (clk),
        .reset      (reset),
        .bus        (bus),
        .ti_pending (ti_pending),
        .rd_data    (timer_rd_data)
    );

    csr_regfile csr_regfile_i (
        .clk           (clk),
        .reset         (reset),
        .bus           (bus),
        .trap_rd_data  (trap_rd_data),
        .timer_rd_data (timer_rd_data),
        .rd_data       (rd_data),
        .eentry        (eentry)
    );

endmodule

`default_nettype wire

/* tests/csr_unit_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_unit_properties (
    input logic       clk,
    input logic       reset,
    input logic       excp_flush,
    input logic [1:0] plv,
    input logic       ie,
    input logic       has_int
);

    // exception entry drops to plv 0 with interrupts off
    property excp_enters_kernel;
        @(posedge clk) disable iff (reset)
        excp_flush |=> (plv == 2'd0) && !ie;
    endproperty

    // no interrupt request while globally masked
    property int_needs_ie;
        @(posedge clk) disable iff (reset)
        has_int |-> ie;
    endproperty

    excp_kernel_a: assert property (excp_enters_kernel)
        else $error("exception entry did not clear plv and ie");

    int_ie_a: assert property (int_needs_ie)
        else $error("has_int raised while crmd.ie is clear");

endmodule

`default_nettype wire

/* tests/csr_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_settings.svh"

module csr_unit_tb;

    localparam int TI_TIMEOUT = 200;

    logic                   clk;
    logic                   reset;
    logic                   csr_wr_en;
    logic [`CSR_ADDR_W-1:0] wr_addr;
    logic [`CSR_DATA_W-1:0] wr_data;
    logic [`CSR_ADDR_W-1:0] rd_addr;
    logic [`CSR_DATA_W-1:0] rd_data;
    logic                   excp_flush;
    logic                   ertn_flush;
    logic [31:0]            era_in;
    logic [5:0]             ecode_in;
    logic [8:0]             esubcode_in;
    logic [`HWI_W-1:0]      interrupt;
    logic                   has_int;
    logic [31:0]            eentry;
    logic [31:0]            era;
    logic [1:0]             plv;
    int                     errors;
    int                     checks;

    csr_unit csr_unit_i (
        .clk         (clk),
        .reset       (reset),
        .csr_wr_en   (csr_wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .excp_flush  (excp_flush),
        .ertn_flush  (ertn_flush),
        .era_in      (era_in),
        .ecode_in    (ecode_in),
        .esubcode_in (esubcode_in),
        .interrupt   (interrupt),
        .has_int     (has_int),
        .eentry      (eentry),
        .era         (era),
        .plv         (plv)
    );

    bind trap_control csr_unit_properties csr_unit_properties_i (
        .clk        (clk),
        .reset      (reset),
        .excp_flush (excp_flush),
        .plv        (plv),
        .ie         (crmd.ie),
        .has_int    (has_int)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic csr_write(input logic [13:0] addr, input logic [31:0] data);
        @(negedge clk);
        csr_wr_en = 1'b1;
        wr_addr = addr;
        wr_data = data;
        @(negedge clk);
        csr_wr_en = 1'b0;
    endtask

    task automatic csr_read(input logic [13:0] addr, input logic [31:0] expected);
        @(negedge clk);
        rd_addr = addr;
        #1;
        check_value($sformatf("rd_data[%h]", addr), rd_data, expected);
    endtask

    task automatic raise_exception(input logic [5:0] ecode, input logic [31:0] pc,
                                   input logic [8:0] esubcode);
        @(negedge clk);
        excp_flush = 1'b1;
        era_in = pc;
        ecode_in = ecode;
        esubcode_in = esubcode;
        @(negedge clk);
        excp_flush = 1'b0;
    endtask

    task automatic return_from_exception();
        @(negedge clk);
        ertn_flush = 1'b1;
        @(negedge clk);
        ertn_flush = 1'b0;
    endtask

    // poll ESTAT.TI
    task automatic wait_for_ti();
        int cycles;
        cycles = 0;
        @(negedge clk);
        rd_addr = `CSR_ESTAT;
        #1;
        while (!rd_data[11] && cycles < TI_TIMEOUT) begin
            @(negedge clk);
            #1;
            cycles++;
        end
        if (!rd_data[11]) begin
            errors++;
            $display("timer interrupt did not show in ESTAT within %0d cycles", TI_TIMEOUT);
        end
    endtask

    task automatic run_case(input logic [3:0] op, input logic [13:0] addr,
                            input logic [31:0] data, input logic [31:0] expected);
        case (op)
            4'h0: csr_write(addr, data);
            4'h1: csr_read(addr, expected);
            4'h2: raise_exception(addr[5:0], data, expected[8:0]);
            4'h3: return_from_exception();
            4'h4: begin
                @(negedge clk);
                interrupt = data[`HWI_W-1:0];
            end
            4'h5: wait_for_ti();
            4'h6: begin
                @(negedge clk);
                check_value("has_int", {31'd0, has_int}, expected);
            end
            4'h7: begin
                @(negedge clk);
                check_value("plv", {30'd0, plv}, expected);
            end
            4'h8: begin
                @(negedge clk);
                check_value("era", era, expected);
            end
            4'h9: begin
                @(negedge clk);
                check_value("eentry", eentry, expected);
            end
            default: begin
                errors++;
                $display("unknown operation %h in the case file", op);
            end
        endcase
    endtask

    initial begin
        int          fd;
        int          count;
        string       line;
        logic [3:0]  op;
        logic [13:0] addr;
        logic [31:0] data;
        logic [31:0] expected;
        errors = 0;
        checks = 0;
        reset = 1'b1;
        csr_wr_en = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        rd_addr = '0;
        excp_flush = 1'b0;
        ertn_flush = 1'b0;
        era_in = '0;
        ecode_in = '0;
        esubcode_in = '0;
        interrupt = '0;
        repeat (16) @(negedge clk);
        reset = 1'b0;

        fd = $fopen("tests/csr_cases.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open tests/csr_cases.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                count = $sscanf(line, "%h %h %h %h", op, addr, data, expected);
                if (count == 4) begin
                    run_case(op, addr, data, expected);
                end
            end
            $fclose(fd);
        end
        if (checks == 0) begin
            errors++;
            $display("no checks were run");
        end

        @(negedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* csr_unit.f */
+incdir+source
source/csr_pkg.sv
source/csr_bus_if.sv
source/trap_control.sv
source/countdown_timer.sv
source/csr_regfile.sv
source/csr_unit.sv
tests/csr_unit_properties.sv
tests/csr_unit_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = csr_unit_tb
FILELIST  = csr_unit.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* tests/csr_cases.txt */
# op addr data expect, all hex. ops: 0 write, 1 read, 2 exception (addr ecode, data era,
# expect esubcode), 3 return, 4 interrupt lines, 5 wait for TI, 6 has_int, 7 plv, 8 era, 9 eentry
1 0000 00000000 00000008
1 0004 00000000 00000000
1 0005 00000000 00000000
7 0000 00000000 00000000
6 0000 00000000 00000000
0 0030 12345678 00000000
0 0031 9abcdef0 00000000
0 0032 deadbeef 00000000
0 0033 0badf00d 00000000
1 0030 00000000 12345678
1 0031 00000000 9abcdef0
1 0032 00000000 deadbeef
1 0033 00000000 0badf00d
0 000c 1c0000ff 00000000
1 000c 00000000 1c0000c0
9 0000 00000000 1c0000c0
0 0000 ffffffff 00000000
1 0000 00000000 000001ff
1 0100 00000000 00000000
# exception entry from plv 3 with interrupts on, then return
0 0000 0000000f 00000000
2 0007 1c001000 00000003
7 0000 00000000 00000000
1 0000 00000000 00000008
1 0001 00000000 00000007
8 0000 00000000 1c001000
1 0005 00000000 00c70000
3 0000 00000000 00000000
7 0000 00000000 00000003
1 0000 00000000 0000000f
# hardware interrupt line 0
0 0004 00000004 00000000
1 0004 00000000 00000004
4 0000 00000001 00000000
6 0000 00000000 00000001
1 0005 00000000 00c70004
0 0000 00000008 00000000
6 0000 00000000 00000000
4 0000 00000000 00000000
# one-shot timer, initval 2
0 0000 00000004 00000000
0 0041 00000009 00000000
5 0000 00000000 00000000
6 0000 00000000 00000000
0 0004 00000800 00000000
6 0000 00000000 00000001
1 0042 00000000 ffffffff
1 0005 00000000 00c70800
0 0044 00000001 00000000
1 0005 00000000 00c70000
6 0000 00000000 00000000
1 0044 00000000 00000000
1 0041 00000000 00000009
